//--- rp_fabric_top.f
rtl/rp_bus_pkg.sv
rtl/rp_analog_pkg.sv
rtl/rp_sys_decoder.sv
rtl/rp_housekeeping.sv
rtl/rp_analog_io.sv
rtl/rp_ams.sv
rtl/rp_pdm.sv
rtl/rp_fabric_top.sv
tb/rp_fabric_chk.sv
tb/rp_fabric_tb.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert --timescale 1ns/100ps
TOP       = rp_fabric_tb
FILELIST  = rp_fabric_top.f
PASS_MSG  = All checks passed

.PHONY: sim clean

# build, run, then look for the pass line in the captured output
sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

//--- tb/rp_fabric_tb.sv
// scope fabric testbench
`timescale 1ns/100ps

module rp_fabric_tb;

  // cycle budget per test, watchdog allows three times the sum
  localparam int unsigned TEST_CYC  = 20 + 200 + 120 + 120 + 80 + 600;
  localparam int unsigned WDOG_CYC  = 3 * TEST_CYC + 400;
  localparam int unsigned ACK_LIMIT = 16;  // cycles a request may stay open
  localparam int          DRV_DLY   = 2;   // ns after the rising edge

  logic                                   adc_clk = 1'b0;
  logic                                   arst_n_i;
  logic [rp_bus_pkg::SYS_AW-1:0]          sys_addr_i;
  logic [rp_bus_pkg::SYS_DW-1:0]          sys_wdata_i;
  logic                                   sys_wen_i;
  logic                                   sys_ren_i;
  logic [rp_bus_pkg::SYS_DW-1:0]          sys_rdata_o;
  logic                                   sys_ack_o;
  logic                                   sys_err_o;
  logic [rp_analog_pkg::ADC_DW-1:0]       adc_dat_a_i;
  logic [rp_analog_pkg::ADC_DW-1:0]       adc_dat_b_i;
  logic signed [rp_analog_pkg::ADC_DW-1:0] adc_a_o;
  logic signed [rp_analog_pkg::ADC_DW-1:0] adc_b_o;
  logic signed [rp_analog_pkg::DAC_DW-1:0] asg_a_i;
  logic signed [rp_analog_pkg::DAC_DW-1:0] asg_b_i;
  logic signed [rp_analog_pkg::DAC_DW-1:0] pid_a_i;
  logic signed [rp_analog_pkg::DAC_DW-1:0] pid_b_i;
  logic [rp_analog_pkg::DAC_DW-1:0]       dac_dat_a_o;
  logic [rp_analog_pkg::DAC_DW-1:0]       dac_dat_b_o;
  logic [rp_analog_pkg::PDM_CHN-1:0]      pdm_o;
  logic [7:0]                             led_o;
  string                                  test_name;

  rp_fabric_top dut_i (.*);

  always #10 adc_clk = ~adc_clk; // 20 ns period

  ////////////////////////////////////////////////////////////////////////////
  // failure reporting and compares
  ////////////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Checks failed");
    $fatal(1, "run aborted");
  endtask

  task automatic cmp_word(input logic [rp_bus_pkg::SYS_DW-1:0] exp_w,
                          input logic [rp_bus_pkg::SYS_DW-1:0] act_w);
    if (act_w !== exp_w)
    begin
      $display("ERR %s: expected %08h, actual %08h", test_name, exp_w, act_w);
      $display("Checks failed");
      $fatal(1, "bus word mismatch");
    end
  endtask

  task automatic cmp_sample(input logic signed [rp_analog_pkg::ADC_DW-1:0] exp_s,
                            input logic signed [rp_analog_pkg::ADC_DW-1:0] act_s);
    if (act_s !== exp_s)
    begin
      $display("ERR %s: expected %0d, actual %0d", test_name, exp_s, act_s);
      $display("Checks failed");
      $fatal(1, "sample mismatch");
    end
  endtask

  task automatic cmp_code(input logic [rp_analog_pkg::DAC_DW-1:0] exp_c,
                          input logic [rp_analog_pkg::DAC_DW-1:0] act_c);
    if (act_c !== exp_c)
    begin
      $display("ERR %s: expected %04h, actual %04h", test_name, exp_c, act_c);
      $display("Checks failed");
      $fatal(1, "dac code mismatch");
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // reference model helpers
  ////////////////////////////////////////////////////////////////////////////

  // sign kept, low 13 bits inverted is the same as 8191 - x, both directions
  function automatic int slope_map(input int x);
    return 8191 - x;
  endfunction

  function automatic int sat_sum(input int a, input int b);
    int s;
    s = a + b;
    if (s > 8191)
      s = 8191;
    else if (s < -8192)
      s = -8192;
    return s;
  endfunction

  function automatic logic signed [rp_analog_pkg::ADC_DW-1:0] to_sample(input int v);
    return v[rp_analog_pkg::ADC_DW-1:0];
  endfunction

  function automatic logic [rp_analog_pkg::DAC_DW-1:0] to_code(input int v);
    return v[rp_analog_pkg::DAC_DW-1:0];
  endfunction

  function automatic logic [rp_analog_pkg::ADC_DW-1:0] rand_raw();
    int unsigned r;
    r = $urandom;
    return r[rp_analog_pkg::ADC_DW-1:0];
  endfunction

  function automatic int rand_sample(); // uniform over -8192..8191
    int unsigned r;
    r = $urandom % 16384;
    return int'(r) - 8192;
  endfunction

  function automatic logic [rp_bus_pkg::SYS_AW-1:0] bus_addr(
    input int unsigned                   region,
    input logic [rp_bus_pkg::SYS_OW-1:0] ofs
  );
    rp_bus_pkg::sys_addr_u a;
    a.raw        = '0;
    a.fld.region = region[rp_bus_pkg::SYS_RW-1:0];
    a.fld.offset = ofs;
    return a.raw;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // bus master
  ////////////////////////////////////////////////////////////////////////////

  // enable is a single cycle pulse, address held until ack
  task automatic wait_ack(output logic [rp_bus_pkg::SYS_DW-1:0] data);
    int unsigned waited;
    logic        done;
    waited = 0;
    done   = 1'b0;
    data   = '0;
    while (!done)
    begin
      @(negedge adc_clk);
      if (sys_ack_o)
      begin
        done = 1'b1;
        data = sys_rdata_o;
      end
      @(posedge adc_clk);
      #DRV_DLY;
      sys_wen_i = 1'b0; // pulse over
      sys_ren_i = 1'b0;
      waited++;
      if (!done && waited >= ACK_LIMIT)
        abort_run("bus request was never acknowledged");
    end
  endtask

  task automatic bus_write(input logic [rp_bus_pkg::SYS_AW-1:0] addr,
                           input logic [rp_bus_pkg::SYS_DW-1:0] data);
    logic [rp_bus_pkg::SYS_DW-1:0] unused_rd;
    @(posedge adc_clk);
    #DRV_DLY;
    sys_addr_i  = addr;
    sys_wdata_i = data;
    sys_wen_i   = 1'b1;
    wait_ack(unused_rd);
  endtask

  task automatic bus_read(input  logic [rp_bus_pkg::SYS_AW-1:0] addr,
                          output logic [rp_bus_pkg::SYS_DW-1:0] data);
    @(posedge adc_clk);
    #DRV_DLY;
    sys_addr_i = addr;
    sys_ren_i  = 1'b1;
    wait_ack(data);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // sample drivers
  ////////////////////////////////////////////////////////////////////////////

  task automatic drive_samples(input int a_asg, input int a_pid, input int b_asg,
                               input int b_pid);
    @(posedge adc_clk);
    #DRV_DLY;
    asg_a_i = a_asg[rp_analog_pkg::DAC_DW-1:0];
    pid_a_i = a_pid[rp_analog_pkg::DAC_DW-1:0];
    asg_b_i = b_asg[rp_analog_pkg::DAC_DW-1:0];
    pid_b_i = b_pid[rp_analog_pkg::DAC_DW-1:0];
  endtask

  // pins captured on the next edge, converted sample checked mid cycle
  task automatic check_adc(input logic [rp_analog_pkg::ADC_DW-1:0] raw_a,
                           input logic [rp_analog_pkg::ADC_DW-1:0] raw_b);
    @(posedge adc_clk);
    #DRV_DLY;
    adc_dat_a_i = raw_a;
    adc_dat_b_i = raw_b;
    @(posedge adc_clk);
    @(negedge adc_clk);
    cmp_sample(to_sample(slope_map(int'(raw_a))), adc_a_o);
    cmp_sample(to_sample(slope_map(int'(raw_b))), adc_b_o);
  endtask

  task automatic check_dac(input int a_asg, input int a_pid, input int b_asg,
                           input int b_pid);
    drive_samples(a_asg, a_pid, b_asg, b_pid);
    @(posedge adc_clk); // output register
    @(negedge adc_clk);
    cmp_code(to_code(slope_map(sat_sum(a_asg, a_pid))), dac_dat_a_o);
    cmp_code(to_code(slope_map(sat_sum(b_asg, b_pid))), dac_dat_b_o);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic test_reset();
    test_name = "test_reset";
    @(negedge adc_clk);
    cmp_word(32'h0, {24'h0, led_o});
    cmp_word(32'h0, {28'h0, pdm_o});
    cmp_code(rp_analog_pkg::DAC_ZERO_CODE, dac_dat_a_o);
    cmp_code(rp_analog_pkg::DAC_ZERO_CODE, dac_dat_b_o);
  endtask

  task automatic test_registers();
    logic [rp_bus_pkg::SYS_DW-1:0] rd;
    logic [7:0]                    duty [rp_analog_pkg::PDM_CHN];
    int unsigned                   r;
    int                            ofs;
    test_name = "test_registers";
    bus_read(bus_addr(rp_bus_pkg::REG_HK, rp_bus_pkg::HK_OFS_ID), rd);
    cmp_word(rp_bus_pkg::HK_ID, rd);
    bus_write(bus_addr(rp_bus_pkg::REG_HK, rp_bus_pkg::HK_OFS_LED), 32'h0000_00a5);
    bus_read(bus_addr(rp_bus_pkg::REG_HK, rp_bus_pkg::HK_OFS_LED), rd);
    cmp_word(32'h0000_00a5, rd);
    @(negedge adc_clk);
    cmp_word(32'h0000_00a5, {24'h0, led_o}); // pins follow the register
    bus_write(bus_addr(rp_bus_pkg::REG_HK, rp_bus_pkg::HK_OFS_LOOP), 32'h1);
    bus_read(bus_addr(rp_bus_pkg::REG_HK, rp_bus_pkg::HK_OFS_LOOP), rd);
    cmp_word(32'h1, rd);
    bus_write(bus_addr(rp_bus_pkg::REG_HK, rp_bus_pkg::HK_OFS_LOOP), 32'h0);
    bus_read(bus_addr(rp_bus_pkg::REG_HK, rp_bus_pkg::HK_OFS_LOOP), rd);
    cmp_word(32'h0, rd);
    // duties, junk in the upper bytes must not stick
    for (int ch = 0; ch < rp_analog_pkg::PDM_CHN; ch++)
    begin
      r        = $urandom;
      duty[ch] = r[7:0];
      ofs      = 4 * ch;
      bus_write(bus_addr(rp_bus_pkg::REG_AMS, rp_bus_pkg::AMS_OFS_PDM + ofs[19:0]), r);
    end
    for (int ch = 0; ch < rp_analog_pkg::PDM_CHN; ch++)
    begin
      ofs = 4 * ch;
      bus_read(bus_addr(rp_bus_pkg::REG_AMS, rp_bus_pkg::AMS_OFS_PDM + ofs[19:0]), rd);
      cmp_word({24'h0, duty[ch]}, rd);
    end
    for (int unsigned reg_n = 1; reg_n < rp_bus_pkg::SYS_REGIONS; reg_n++)
    begin
      if (reg_n != rp_bus_pkg::REG_AMS)
      begin
        bus_read(bus_addr(reg_n, 20'h00010), rd); // empty region
        cmp_word(32'h0, rd);
      end
    end
  endtask

  task automatic test_adc();
    test_name = "test_adc";
    repeat (40)
      check_adc(rand_raw(), rand_raw());
  endtask

  task automatic test_dac();
    // corner pairs, both overflow directions included
    int pairs [12] = '{8191, 8191, -8192, -8192, 8191, -8192, 0, 0,
                       4096, 4096, -4096, -4097};
    int nxt;
    test_name = "test_dac";
    for (int k = 0; k < 6; k++)
    begin
      nxt = (k + 1) % 6;
      check_dac(pairs[2*k], pairs[2*k+1], pairs[2*nxt], pairs[2*nxt+1]);
    end
    repeat (30)
      check_dac(rand_sample(), rand_sample(), rand_sample(), rand_sample());
  endtask

  task automatic test_loop();
    int a_asg, a_pid, b_asg, b_pid;
    test_name = "test_loop";
    bus_write(bus_addr(rp_bus_pkg::REG_HK, rp_bus_pkg::HK_OFS_LOOP), 32'h1);
    repeat (12)
    begin
      a_asg = rand_sample();
      a_pid = rand_sample();
      b_asg = rand_sample();
      b_pid = rand_sample();
      drive_samples(a_asg, a_pid, b_asg, b_pid);
      @(negedge adc_clk); // same cycle, no register in the loop
      cmp_sample(to_sample(sat_sum(a_asg, a_pid)), adc_a_o);
      cmp_sample(to_sample(sat_sum(b_asg, b_pid)), adc_b_o);
    end
    bus_write(bus_addr(rp_bus_pkg::REG_HK, rp_bus_pkg::HK_OFS_LOOP), 32'h0);
    repeat (4)
      check_adc(rand_raw(), rand_raw());
  endtask

  task automatic test_pdm();
    int duty [rp_analog_pkg::PDM_CHN] = '{0, 1, 128, 255};
    int ones [rp_analog_pkg::PDM_CHN] = '{0, 0, 0, 0};
    int ofs;
    test_name = "test_pdm";
    for (int ch = 0; ch < rp_analog_pkg::PDM_CHN; ch++)
    begin
      ofs = 4 * ch;
      bus_write(bus_addr(rp_bus_pkg::REG_AMS, rp_bus_pkg::AMS_OFS_PDM + ofs[19:0]),
                duty[ch]);
    end
    repeat (256) @(posedge adc_clk); // settle
    repeat (256)
    begin
      @(negedge adc_clk);
      for (int ch = 0; ch < rp_analog_pkg::PDM_CHN; ch++)
        ones[ch] += int'(pdm_o[ch]);
    end
    for (int ch = 0; ch < rp_analog_pkg::PDM_CHN; ch++)
      cmp_word(duty[ch], ones[ch]); // high cycles per 256 equal the duty
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // run control
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin
    repeat (WDOG_CYC) @(posedge adc_clk);
    abort_run("watchdog expired before the tests finished");
  end

  initial
  begin
    void'($urandom(8));
    arst_n_i    = 1'b0;
    sys_addr_i  = '0;
    sys_wdata_i = '0;
    sys_wen_i   = 1'b0;
    sys_ren_i   = 1'b0;
    adc_dat_a_i = '0;
    adc_dat_b_i = '0;
    asg_a_i     = '0;
    asg_b_i     = '0;
    pid_a_i     = '0;
    pid_b_i     = '0;
    test_name   = "init";
    repeat (4) @(posedge adc_clk);
    #DRV_DLY;
    arst_n_i = 1'b1;
    test_reset();
    test_registers();
    test_adc();
    test_dac();
    test_loop();
    test_pdm();
    @(posedge adc_clk);
    if (dut_i.chk_i.fail_cnt == 0)
    begin
      $display("All checks passed");
      $finish;
    end
    else
    begin
      $display("Checks failed");
      $fatal(1, "assertion failures in the bus checker");
    end
  end

endmodule

//--- tb/rp_fabric_chk.sv
// bus protocol assertions
`timescale 1ns/100ps

module rp_fabric_chk (
  input logic adc_clk,
  input logic arst_n_i,
  input logic wen_i,
  input logic ren_i,
  input logic ack_i,
  input logic err_i
);

  int unsigned fail_cnt = 0; // read by the testbench at the end

  // no slave ever signals an error
  err_low: assert property (@(posedge adc_clk) disable iff (!arst_n_i) !err_i)
    else
    begin
      $error("bus error response seen");
      fail_cnt++;
    end

  // ack only with the strobe (unused regions) or one cycle later (real slaves)
  ack_window: assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    ack_i |-> (wen_i || ren_i || $past(wen_i || ren_i)))
    else
    begin
      $error("bus ack without a request in this or the previous cycle");
      fail_cnt++;
    end

endmodule

bind rp_fabric_top rp_fabric_chk chk_i (
  .adc_clk  (adc_clk),
  .arst_n_i (arst_n_i),
  .wen_i    (sys_wen_i),
  .ren_i    (sys_ren_i),
  .ack_i    (sys_ack_o),
  .err_i    (sys_err_o)
);

//--- rtl/rp_fabric_top.sv
// scope and generator fabric top
`timescale 1ns/100ps

module rp_fabric_top (
  input  logic                                              adc_clk,
  input  logic                                              arst_n_i,
  // system bus, master outside
  input  logic [rp_bus_pkg::SYS_AW-1:0]                     sys_addr_i,
  input  logic [rp_bus_pkg::SYS_DW-1:0]                     sys_wdata_i,
  input  logic                                              sys_wen_i,
  input  logic                                              sys_ren_i,
  output logic [rp_bus_pkg::SYS_DW-1:0]                     sys_rdata_o,
  output logic                                              sys_ack_o,
  output logic                                              sys_err_o,
  // adc pins and converted samples
  input  logic [rp_analog_pkg::ADC_DW+rp_analog_pkg::ADC_RAW_LSB-1:rp_analog_pkg::ADC_RAW_LSB]
                                                            adc_dat_a_i,
  input  logic [rp_analog_pkg::ADC_DW+rp_analog_pkg::ADC_RAW_LSB-1:rp_analog_pkg::ADC_RAW_LSB]
                                                            adc_dat_b_i,
  output logic signed [rp_analog_pkg::ADC_DW-1:0]           adc_a_o,
  output logic signed [rp_analog_pkg::ADC_DW-1:0]           adc_b_o,
  // generator and controller samples
  input  logic signed [rp_analog_pkg::DAC_DW-1:0]           asg_a_i,
  input  logic signed [rp_analog_pkg::DAC_DW-1:0]           asg_b_i,
  input  logic signed [rp_analog_pkg::DAC_DW-1:0]           pid_a_i,
  input  logic signed [rp_analog_pkg::DAC_DW-1:0]           pid_b_i,
  // outputs
  output logic [rp_analog_pkg::DAC_DW-1:0]                  dac_dat_a_o,
  output logic [rp_analog_pkg::DAC_DW-1:0]                  dac_dat_b_o,
  output logic [rp_analog_pkg::PDM_CHN-1:0]                 pdm_o,
  output logic [7:0]                                        led_o
);

  ////////////////////////////////////////////////////////////////////////////
  // bus fan-out
  ////////////////////////////////////////////////////////////////////////////

  logic [rp_bus_pkg::SYS_REGIONS-1:0]                         slv_wen;
  logic [rp_bus_pkg::SYS_REGIONS-1:0]                         slv_ren;
  logic [rp_bus_pkg::SYS_REGIONS-1:0][rp_bus_pkg::SYS_DW-1:0] slv_rdata;
  logic [rp_bus_pkg::SYS_REGIONS-1:0]                         slv_ack;
  logic [rp_bus_pkg::SYS_REGIONS-1:0]                         slv_err;

  logic                                                       digital_loop;
  logic [rp_analog_pkg::PDM_CHN-1:0][rp_analog_pkg::PDM_DWC-1:0] pdm_cfg;

  // regions 1..3 and 5..7 have no slave, decoder answers them itself
  assign slv_rdata[3:1] = '0;
  assign slv_rdata[7:5] = '0;
  assign slv_ack[3:1]   = '0;
  assign slv_ack[7:5]   = '0;
  assign slv_err[3:1]   = '0;
  assign slv_err[7:5]   = '0;

  rp_sys_decoder sys_dec_i (
    .adc_clk     (adc_clk),
    .arst_n_i    (arst_n_i),
    .sys_addr_i  (sys_addr_i),
    .sys_wen_i   (sys_wen_i),
    .sys_ren_i   (sys_ren_i),
    .sys_rdata_o (sys_rdata_o),
    .sys_ack_o   (sys_ack_o),
    .sys_err_o   (sys_err_o),
    .slv_wen_o   (slv_wen),
    .slv_ren_o   (slv_ren),
    .slv_rdata_i (slv_rdata),
    .slv_ack_i   (slv_ack),
    .slv_err_i   (slv_err)
  );

  ////////////////////////////////////////////////////////////////////////////
  // slaves and data path
  ////////////////////////////////////////////////////////////////////////////

  rp_housekeeping hk_i (
    .adc_clk        (adc_clk),
    .arst_n_i       (arst_n_i),
    .sys_addr_i     (sys_addr_i),
    .sys_wdata_i    (sys_wdata_i),
    .sys_wen_i      (slv_wen[rp_bus_pkg::REG_HK]),
    .sys_ren_i      (slv_ren[rp_bus_pkg::REG_HK]),
    .sys_rdata_o    (slv_rdata[rp_bus_pkg::REG_HK]),
    .sys_ack_o      (slv_ack[rp_bus_pkg::REG_HK]),
    .sys_err_o      (slv_err[rp_bus_pkg::REG_HK]),
    .digital_loop_o (digital_loop),
    .led_o          (led_o)
  );

  rp_analog_io analog_i (
    .adc_clk        (adc_clk),
    .arst_n_i       (arst_n_i),
    .adc_dat_a_i    (adc_dat_a_i),
    .adc_dat_b_i    (adc_dat_b_i),
    .digital_loop_i (digital_loop),
    .asg_a_i        (asg_a_i),
    .asg_b_i        (asg_b_i),
    .pid_a_i        (pid_a_i),
    .pid_b_i        (pid_b_i),
    .adc_a_o        (adc_a_o),
    .adc_b_o        (adc_b_o),
    .dac_dat_a_o    (dac_dat_a_o),
    .dac_dat_b_o    (dac_dat_b_o)
  );

  rp_ams ams_i (
    .adc_clk     (adc_clk),
    .arst_n_i    (arst_n_i),
    .sys_addr_i  (sys_addr_i),
    .sys_wdata_i (sys_wdata_i),
    .sys_wen_i   (slv_wen[rp_bus_pkg::REG_AMS]),
    .sys_ren_i   (slv_ren[rp_bus_pkg::REG_AMS]),
    .sys_rdata_o (slv_rdata[rp_bus_pkg::REG_AMS]),
    .sys_ack_o   (slv_ack[rp_bus_pkg::REG_AMS]),
    .sys_err_o   (slv_err[rp_bus_pkg::REG_AMS]),
    .pdm_cfg_o   (pdm_cfg)
  );

  rp_pdm pdm_i (
    .adc_clk   (adc_clk),
    .arst_n_i  (arst_n_i),
    .pdm_cfg_i (pdm_cfg),
    .pdm_o     (pdm_o)
  );

endmodule

//--- rtl/rp_pdm.sv
// first order pulse density modulator
`timescale 1ns/100ps

module rp_pdm (
  input  logic                                                          adc_clk,
  input  logic                                                          arst_n_i,
  input  logic [rp_analog_pkg::PDM_CHN-1:0][rp_analog_pkg::PDM_DWC-1:0] pdm_cfg_i,
  output logic [rp_analog_pkg::PDM_CHN-1:0]                             pdm_o
);

  logic [rp_analog_pkg::PDM_CHN-1:0][rp_analog_pkg::PDM_DWC-1:0] acc_q;
  logic [rp_analog_pkg::PDM_CHN-1:0][rp_analog_pkg::PDM_DWC:0]   sum;   // carry on top

  // duty of d gives d carries every 2**PDM_DWC cycles
  always_comb
  begin
    for (int ch = 0; ch < rp_analog_pkg::PDM_CHN; ch++)
      sum[ch] = {1'b0, acc_q[ch]} + {1'b0, pdm_cfg_i[ch]};
  end

  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      acc_q <= '0;
      pdm_o <= '0;
    end
    else
    begin
      for (int ch = 0; ch < rp_analog_pkg::PDM_CHN; ch++)
      begin
        acc_q[ch] <= sum[ch][rp_analog_pkg::PDM_DWC-1:0]; // wraps
        pdm_o[ch] <= sum[ch][rp_analog_pkg::PDM_DWC];     // registered carry
      end
    end
  end

endmodule

//--- rtl/rp_ams.sv
// mixed signal register bank
`timescale 1ns/100ps

module rp_ams (
  input  logic                          adc_clk,
  input  logic                          arst_n_i,
  // region 4 slave port
  input  logic [rp_bus_pkg::SYS_AW-1:0] sys_addr_i,
  input  logic [rp_bus_pkg::SYS_DW-1:0] sys_wdata_i,
  input  logic                          sys_wen_i,
  input  logic                          sys_ren_i,
  output logic [rp_bus_pkg::SYS_DW-1:0] sys_rdata_o,
  output logic                          sys_ack_o,
  output logic                          sys_err_o,
  // duties for the modulator
  output logic [rp_analog_pkg::PDM_CHN-1:0][rp_analog_pkg::PDM_DWC-1:0] pdm_cfg_o
);

  rp_bus_pkg::sys_addr_u                                         addr;
  logic [rp_analog_pkg::PDM_CHN-1:0]                             hit;    // per channel
  logic [rp_analog_pkg::PDM_CHN-1:0][rp_analog_pkg::PDM_DWC-1:0] duty_q;
  logic                                                          ack_q;
  logic [rp_bus_pkg::SYS_DW-1:0]                                 rd_nxt;
  logic [rp_bus_pkg::SYS_DW-1:0]                                 rdata_q;

  assign addr.raw = sys_addr_i;

  // channel n at base + n words
  always_comb
  begin
    logic [rp_bus_pkg::SYS_OW-1:0] ch_ofs;
    ch_ofs = rp_bus_pkg::AMS_OFS_PDM;
    rd_nxt = '0;
    for (int ch = 0; ch < rp_analog_pkg::PDM_CHN; ch++)
    begin
      hit[ch] = (addr.fld.offset == ch_ofs);
      if (hit[ch])
        rd_nxt[rp_analog_pkg::PDM_DWC-1:0] = duty_q[ch]; // zero extended
      ch_ofs = ch_ofs + rp_bus_pkg::AMS_OFS_STEP;
    end
  end

  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      duty_q <= '0;
      ack_q  <= 1'b0;
    end
    else
    begin
      ack_q <= sys_wen_i | sys_ren_i;
      for (int ch = 0; ch < rp_analog_pkg::PDM_CHN; ch++)
      begin
        if (sys_wen_i && hit[ch])
          duty_q[ch] <= sys_wdata_i[rp_analog_pkg::PDM_DWC-1:0]; // low byte only
      end
    end
  end

  always_ff @(posedge adc_clk)
  begin
    if (sys_ren_i)
      rdata_q <= rd_nxt;
  end

  assign sys_rdata_o = rdata_q;
  assign sys_ack_o   = ack_q;
  assign sys_err_o   = 1'b0;
  assign pdm_cfg_o   = duty_q;

endmodule

//--- rtl/rp_analog_io.sv
// adc and dac sample path
`timescale 1ns/100ps

module rp_analog_io (
  input  logic                                    adc_clk,
  input  logic                                    arst_n_i,
  // raw adc pins, low reserved bits dropped
  input  logic [rp_analog_pkg::ADC_DW+rp_analog_pkg::ADC_RAW_LSB-1:rp_analog_pkg::ADC_RAW_LSB]
                                                  adc_dat_a_i,
  input  logic [rp_analog_pkg::ADC_DW+rp_analog_pkg::ADC_RAW_LSB-1:rp_analog_pkg::ADC_RAW_LSB]
                                                  adc_dat_b_i,
  input  logic                                    digital_loop_i,
  // generator and controller
  input  logic signed [rp_analog_pkg::DAC_DW-1:0] asg_a_i,
  input  logic signed [rp_analog_pkg::DAC_DW-1:0] asg_b_i,
  input  logic signed [rp_analog_pkg::DAC_DW-1:0] pid_a_i,
  input  logic signed [rp_analog_pkg::DAC_DW-1:0] pid_b_i,
  // samples and codes
  output logic signed [rp_analog_pkg::ADC_DW-1:0] adc_a_o,
  output logic signed [rp_analog_pkg::ADC_DW-1:0] adc_b_o,
  output logic [rp_analog_pkg::DAC_DW-1:0]        dac_dat_a_o,
  output logic [rp_analog_pkg::DAC_DW-1:0]        dac_dat_b_o
);

  // negative slope <-> two's complement, same map both ways
  function automatic logic [rp_analog_pkg::DAC_DW-1:0] flip_slope(
    input logic [rp_analog_pkg::DAC_DW-1:0] val
  );
    return {val[rp_analog_pkg::DAC_DW-1], ~val[rp_analog_pkg::DAC_DW-2:0]};
  endfunction

  // clamp to +8191 / -8192 when the top two sum bits differ
  function automatic logic [rp_analog_pkg::DAC_DW-1:0] clamp(
    input logic [rp_analog_pkg::SUM_DW-1:0] sum
  );
    logic sgn;
    sgn = sum[rp_analog_pkg::SUM_DW-1];
    if (sgn ^ sum[rp_analog_pkg::SUM_DW-2])
      return {sgn, {(rp_analog_pkg::DAC_DW-1){~sgn}}};
    return sum[rp_analog_pkg::DAC_DW-1:0];
  endfunction

  logic [rp_analog_pkg::ADC_DW-1:0] adc_raw_a_q, adc_raw_b_q;
  logic [rp_analog_pkg::SUM_DW-1:0] dac_sum_a, dac_sum_b;
  logic [rp_analog_pkg::DAC_DW-1:0] dac_a, dac_b;  // saturated, two's complement

  ////////////////////////////////////////////////////////////////////////////
  // adc side
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      adc_raw_a_q <= '0;
      adc_raw_b_q <= '0;
    end
    else
    begin
      adc_raw_a_q <= adc_dat_a_i; // pin capture
      adc_raw_b_q <= adc_dat_b_i;
    end
  end

  // loop takes the dac value before its output register
  assign adc_a_o = digital_loop_i ? dac_a : flip_slope(adc_raw_a_q);
  assign adc_b_o = digital_loop_i ? dac_b : flip_slope(adc_raw_b_q);

  ////////////////////////////////////////////////////////////////////////////
  // dac side
  ////////////////////////////////////////////////////////////////////////////

  assign dac_sum_a = {asg_a_i[rp_analog_pkg::DAC_DW-1], asg_a_i}
                   + {pid_a_i[rp_analog_pkg::DAC_DW-1], pid_a_i};
  assign dac_sum_b = {asg_b_i[rp_analog_pkg::DAC_DW-1], asg_b_i}
                   + {pid_b_i[rp_analog_pkg::DAC_DW-1], pid_b_i};
  assign dac_a     = clamp(dac_sum_a);
  assign dac_b     = clamp(dac_sum_b);

  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      dac_dat_a_o <= rp_analog_pkg::DAC_ZERO_CODE; // mid scale out of reset
      dac_dat_b_o <= rp_analog_pkg::DAC_ZERO_CODE;
    end
    else
    begin
      dac_dat_a_o <= flip_slope(dac_a);
      dac_dat_b_o <= flip_slope(dac_b);
    end
  end

endmodule

//--- rtl/rp_housekeeping.sv
// housekeeping register bank
`timescale 1ns/100ps

module rp_housekeeping (
  input  logic                          adc_clk,
  input  logic                          arst_n_i,
  // region 0 slave port
  input  logic [rp_bus_pkg::SYS_AW-1:0] sys_addr_i,
  input  logic [rp_bus_pkg::SYS_DW-1:0] sys_wdata_i,
  input  logic                          sys_wen_i,
  input  logic                          sys_ren_i,
  output logic [rp_bus_pkg::SYS_DW-1:0] sys_rdata_o,
  output logic                          sys_ack_o,
  output logic                          sys_err_o,
  // configuration
  output logic                          digital_loop_o,
  output logic [7:0]                    led_o
);

  rp_bus_pkg::sys_addr_u         addr;
  logic                          loop_q;
  logic [7:0]                    led_q;
  logic                          ack_q;
  logic [rp_bus_pkg::SYS_DW-1:0] rd_nxt;
  logic [rp_bus_pkg::SYS_DW-1:0] rdata_q;

  assign addr.raw = sys_addr_i;

  ////////////////////////////////////////////////////////////////////////////
  // write side
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      loop_q <= 1'b0;
      led_q  <= '0;
      ack_q  <= 1'b0;
    end
    else
    begin
      ack_q <= sys_wen_i | sys_ren_i; // every access answered next cycle
      if (sys_wen_i)
      begin
        case (addr.fld.offset)
          rp_bus_pkg::HK_OFS_LOOP: loop_q <= sys_wdata_i[0];
          rp_bus_pkg::HK_OFS_LED:  led_q  <= sys_wdata_i[7:0];
          default: ; // id is read only
        endcase
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // read side
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    rd_nxt = '0; // unknown offsets
    case (addr.fld.offset)
      rp_bus_pkg::HK_OFS_ID:   rd_nxt         = rp_bus_pkg::HK_ID;
      rp_bus_pkg::HK_OFS_LOOP: rd_nxt[0]      = loop_q;
      rp_bus_pkg::HK_OFS_LED:  rd_nxt[7:0]    = led_q;
      default: ;
    endcase
  end

  always_ff @(posedge adc_clk)
  begin
    if (sys_ren_i)
      rdata_q <= rd_nxt;
  end

  assign sys_rdata_o    = rdata_q;
  assign sys_ack_o      = ack_q;
  assign sys_err_o      = 1'b0; // no failing access here
  assign digital_loop_o = loop_q;
  assign led_o          = led_q;

endmodule

//--- rtl/rp_sys_decoder.sv
// system bus region decoder
`timescale 1ns/100ps

module rp_sys_decoder (
  input  logic                                                       adc_clk,
  input  logic                                                       arst_n_i,
  // master side
  input  logic [rp_bus_pkg::SYS_AW-1:0]                              sys_addr_i,
  input  logic                                                       sys_wen_i,
  input  logic                                                       sys_ren_i,
  output logic [rp_bus_pkg::SYS_DW-1:0]                              sys_rdata_o,
  output logic                                                       sys_ack_o,
  output logic                                                       sys_err_o,
  // slave side with one entry per region
  output logic [rp_bus_pkg::SYS_REGIONS-1:0]                         slv_wen_o,
  output logic [rp_bus_pkg::SYS_REGIONS-1:0]                         slv_ren_o,
  input  logic [rp_bus_pkg::SYS_REGIONS-1:0][rp_bus_pkg::SYS_DW-1:0] slv_rdata_i,
  input  logic [rp_bus_pkg::SYS_REGIONS-1:0]                         slv_ack_i,
  input  logic [rp_bus_pkg::SYS_REGIONS-1:0]                         slv_err_i
);

  rp_bus_pkg::sys_addr_u              addr;
  logic [rp_bus_pkg::SYS_REGIONS-1:0] sel;         // one-hot region
  logic [rp_bus_pkg::SYS_RW-1:0]      pend_q;      // region of last request
  logic [rp_bus_pkg::SYS_RW-1:0]      rsp_reg;     // region routed back
  logic                               rsp_slave;   // routed region has a real slave
  logic                               strobe;

  assign addr.raw = sys_addr_i;
  assign strobe   = sys_wen_i | sys_ren_i;

  always_comb
  begin
    sel                  = '0;
    sel[addr.fld.region] = 1'b1;
  end

  // strobes only reach the addressed region
  assign slv_wen_o = sel & {rp_bus_pkg::SYS_REGIONS{sys_wen_i}};
  assign slv_ren_o = sel & {rp_bus_pkg::SYS_REGIONS{sys_ren_i}};

  // remember where the request went since slaves answer one cycle later
  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
      pend_q <= '0;
    else if (strobe)
      pend_q <= addr.fld.region;
  end

  assign rsp_reg   = strobe ? addr.fld.region : pend_q;
  assign rsp_slave = (int'(rsp_reg) == rp_bus_pkg::REG_HK)
                   || (int'(rsp_reg) == rp_bus_pkg::REG_AMS);

  // unused regions give zero data and an ack with the strobe
  assign sys_ack_o   = rsp_slave ? slv_ack_i[rsp_reg] : strobe;
  assign sys_rdata_o = rsp_slave ? slv_rdata_i[rsp_reg] : '0;
  assign sys_err_o   = rsp_slave & slv_err_i[rsp_reg];

endmodule

//--- rtl/rp_analog_pkg.sv
// analog path definitions

package rp_analog_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // sample widths
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned ADC_DW      = 14; // adc sample
  localparam int unsigned DAC_DW      = 14; // dac sample
  localparam int unsigned SUM_DW      = 15; // asg + pid before clamping
  localparam int unsigned ADC_RAW_LSB = 2;  // reserved low pins of the 16 bit adc

  // pulse density outputs
  localparam int unsigned PDM_CHN = 4;
  localparam int unsigned PDM_DWC = 8; // duty resolution

  // negative slope code of sample zero
  // sign 0, remaining bits inverted
  localparam logic [DAC_DW-1:0] DAC_ZERO_CODE = 14'h1FFF;

endpackage

//--- rtl/rp_bus_pkg.sv
// system bus definitions

package rp_bus_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // bus geometry
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned SYS_AW      = 32; // address width
  localparam int unsigned SYS_DW      = 32; // data width
  localparam int unsigned SYS_RW      = 3;  // region field, address bits 22..20
  localparam int unsigned SYS_OW      = 20; // byte offset inside one region
  localparam int unsigned SYS_REGIONS = 8;

  // regions with a slave behind them
  localparam int unsigned REG_HK  = 0; // housekeeping
  localparam int unsigned REG_AMS = 4; // mixed signal bank

  // housekeeping map
  localparam logic [SYS_DW-1:0] HK_ID       = 32'h5250_0100; // read only id word
  localparam logic [SYS_OW-1:0] HK_OFS_ID   = 20'h00000;
  localparam logic [SYS_OW-1:0] HK_OFS_LOOP = 20'h00004; // digital loop, bit 0
  localparam logic [SYS_OW-1:0] HK_OFS_LED  = 20'h00030;

  // pdm duties, one word per channel
  localparam logic [SYS_OW-1:0] AMS_OFS_PDM  = 20'h00020;
  localparam logic [SYS_OW-1:0] AMS_OFS_STEP = 20'h00004;

  // address seen two ways: raw word or region/offset split
  typedef struct packed {
    logic [SYS_AW-SYS_RW-SYS_OW-1:0] unused; // upper bits, ignored
    logic [SYS_RW-1:0]               region;
    logic [SYS_OW-1:0]               offset;
  } sys_addr_s;

  typedef union packed {
    logic [SYS_AW-1:0] raw;
    sys_addr_s         fld;
  } sys_addr_u;

endpackage
